//--- Bender.yml
package:
  name: coproc

sources:
  - files:
      - design/coproc_pkg.sv
      - design/issue_if.sv
      - design/exec_if.sv
      - design/instr_decoder.sv
      - design/issue_queue.sv
      - design/bitfunc_unit.sv
      - design/result_stage.sv
      - design/coproc_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_coproc.sv

//--- design/bitfunc_unit.sv
// Combinational population count, leading-one index and lane maximum of one operand
`timescale 1ns/1ns

module bitfunc_unit (
  input  coproc_pkg::op_kind_e          op_kind_i,
  input  coproc_pkg::lane_width_e       lane_width_i,
  input  logic [coproc_pkg::XLEN-1:0]   operand_i,
  output logic [coproc_pkg::XLEN-1:0]   result_o
);
  import coproc_pkg::*;

  localparam int unsigned Levels = $clog2(XLEN);

  // Level l holds XLEN >> l partial counts
  logic [Levels:0]   pop_sum [Levels+1][XLEN];
  logic [Levels-1:0] lead_idx;
  logic [XLEN-1:0]   lane_max [3];

  for (genvar i = 0; i < XLEN; i++) begin : g_pop_leaf
    assign pop_sum[0][i] = {{Levels{1'b0}}, operand_i[i]};
  end

  for (genvar l = 1; l <= Levels; l++) begin : g_pop_level
    for (genvar i = 0; i < (XLEN >> l); i++) begin : g_pop_node
      assign pop_sum[l][i] = pop_sum[l-1][2*i] + pop_sum[l-1][2*i+1];
    end
  end

  // Highest set bit wins, zero operand leaves the index at 0
  always_comb begin
    lead_idx = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (operand_i[i]) begin
        lead_idx = Levels'(i);
      end
    end
  end

  // One max tree per lane width, bytes first
  for (genvar k = 0; k < 3; k++) begin : g_lane
    localparam int unsigned LaneW    = 8 << k;
    localparam int unsigned NumLanes = XLEN / LaneW;

    logic [LaneW-1:0] best;

    always_comb begin
      best = '0;
      for (int i = 0; i < NumLanes; i++) begin
        if (operand_i[i*LaneW +: LaneW] > best) begin
          best = operand_i[i*LaneW +: LaneW];
        end
      end
    end

    assign lane_max[k] = {{(XLEN-LaneW){1'b0}}, best};
  end

  always_comb begin
    result_o = '0;
    case (op_kind_i)
      OP_POPCNT:  result_o = {{(XLEN-Levels-1){1'b0}}, pop_sum[Levels][0]};
      OP_LEADONE: result_o = {{(XLEN-Levels){1'b0}}, lead_idx};
      OP_LANEMAX: begin
        case (lane_width_i)
          LANE_BYTE: result_o = lane_max[0];
          LANE_HALF: result_o = lane_max[1];
          LANE_WORD: result_o = lane_max[2];
          default:   result_o = '0;
        endcase
      end
      default: result_o = '0;
    endcase
  end

endmodule

//--- design/coproc_pkg.sv
// Widths, opcodes and the queue entry type shared by all coprocessor RTL, compiled first
package coproc_pkg;

  localparam int unsigned XLEN           = 64;
  localparam int unsigned ILEN           = 32;
  localparam int unsigned ID_WIDTH       = 4;
  localparam int unsigned REG_ADDR_WIDTH = 5;

  // Major opcodes of the custom instructions
  localparam logic [6:0] OPCODE_POPCNT  = 7'b1011011;
  localparam logic [6:0] OPCODE_LEADONE = 7'b1111011;
  localparam logic [6:0] OPCODE_LANEMAX = 7'b0001011;

  typedef enum logic [1:0] {
    OP_POPCNT  = 2'b00,
    OP_LEADONE = 2'b01,
    OP_LANEMAX = 2'b10
  } op_kind_e;

  // Encoded as rs2[1:0], 2'b11 is not a legal lane width
  typedef enum logic [1:0] {
    LANE_BYTE = 2'b00,
    LANE_HALF = 2'b01,
    LANE_WORD = 2'b10
  } lane_width_e;

  typedef struct packed {
    logic [ID_WIDTH-1:0]       id;
    logic [REG_ADDR_WIDTH-1:0] rd;
    op_kind_e                  op_kind;
    lane_width_e               lane_width;
    logic [XLEN-1:0]           rs1;
  } queue_entry_t;

endpackage

//--- design/coproc_top.sv
// Coprocessor top level with plain issue, commit and result ports for the host core
`timescale 1ns/1ns

module coproc_top #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  issue_valid_i,
  input  logic [coproc_pkg::ILEN-1:0]           issue_instr_i,
  input  logic [coproc_pkg::XLEN-1:0]           issue_rs1_i,
  input  logic [coproc_pkg::XLEN-1:0]           issue_rs2_i,
  input  logic [coproc_pkg::ID_WIDTH-1:0]       issue_id_i,
  output logic                                  issue_ready_o,
  output logic                                  issue_accept_o,
  output logic                                  issue_writeback_o,
  input  logic                                  commit_valid_i,
  input  logic                                  commit_kill_i,
  output logic                                  result_valid_o,
  input  logic                                  result_ready_i,
  output logic [coproc_pkg::ID_WIDTH-1:0]       result_id_o,
  output logic [coproc_pkg::REG_ADDR_WIDTH-1:0] result_rd_o,
  output logic [coproc_pkg::XLEN-1:0]           result_data_o,
  output logic                                  result_we_o
);

  issue_if u_issue_if ();
  exec_if  u_exec_if ();

  instr_decoder u_decoder (
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_id_i        (issue_id_i),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .issue_ready_o     (issue_ready_o),
    .issue_o           (u_issue_if.decoder)
  );

  issue_queue #(
    .QueueDepth (QueueDepth)
  ) u_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_valid_i (commit_valid_i),
    .commit_kill_i  (commit_kill_i),
    .issue_i        (u_issue_if.queue),
    .exec_o         (u_exec_if.queue)
  );

  result_stage u_result (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result_ready_i (result_ready_i),
    .exec_i         (u_exec_if.consumer),
    .result_valid_o (result_valid_o),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .result_we_o    (result_we_o)
  );

endmodule

//--- design/exec_if.sv
// Valid/ready channel that offers the committed head of the issue queue for execution
`timescale 1ns/1ns

interface exec_if;
  import coproc_pkg::*;

  logic         valid;
  logic         ready;
  queue_entry_t entry;

  modport queue (
    output valid,
    output entry,
    input  ready
  );

  modport consumer (
    input  valid,
    input  entry,
    output ready
  );

endinterface

//--- design/instr_decoder.sv
// Issue decoder that accepts the three custom opcodes and builds the entry for the issue queue
`timescale 1ns/1ns

module instr_decoder (
  input  logic                            issue_valid_i,
  input  logic [coproc_pkg::ILEN-1:0]     issue_instr_i,
  input  logic [coproc_pkg::XLEN-1:0]     issue_rs1_i,
  input  logic [coproc_pkg::XLEN-1:0]     issue_rs2_i,
  input  logic [coproc_pkg::ID_WIDTH-1:0] issue_id_i,
  output logic                            issue_accept_o,
  output logic                            issue_writeback_o,
  output logic                            issue_ready_o,
  issue_if.decoder                        issue_o
);
  import coproc_pkg::*;

  logic        opcode_ok;
  logic        lane_ok;
  op_kind_e    op_kind;
  lane_width_e lane_width;

  always_comb begin
    opcode_ok  = 1'b1;
    op_kind    = OP_POPCNT;
    lane_width = LANE_BYTE;
    lane_ok    = 1'b1;
    case (issue_instr_i[6:0])
      OPCODE_POPCNT:  op_kind = OP_POPCNT;
      OPCODE_LEADONE: op_kind = OP_LEADONE;
      OPCODE_LANEMAX: begin
        op_kind    = OP_LANEMAX;
        lane_width = lane_width_e'(issue_rs2_i[1:0]);
        lane_ok    = issue_rs2_i[1:0] != 2'b11;
      end
      default: opcode_ok = 1'b0;
    endcase
  end

  assign issue_accept_o    = issue_valid_i && opcode_ok && lane_ok;
  assign issue_writeback_o = issue_accept_o;
  assign issue_ready_o     = issue_o.ready;

  // Rejected instructions never reach the queue
  assign issue_o.valid            = issue_accept_o;
  assign issue_o.entry.id         = issue_id_i;
  assign issue_o.entry.rd         = issue_instr_i[11:7];
  assign issue_o.entry.op_kind    = op_kind;
  assign issue_o.entry.lane_width = lane_width;
  assign issue_o.entry.rs1        = issue_rs1_i;

endmodule

//--- design/issue_if.sv
// Valid/ready channel that hands an accepted, decoded instruction to the issue queue
`timescale 1ns/1ns

interface issue_if;
  import coproc_pkg::*;

  logic         valid;
  logic         ready;
  queue_entry_t entry;

  modport decoder (
    output valid,
    output entry,
    input  ready
  );

  modport queue (
    input  valid,
    input  entry,
    output ready
  );

endinterface

//--- design/issue_queue.sv
// In-order instruction queue, holds accepted entries until commit or kill releases the head
`timescale 1ns/1ns

module issue_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    commit_valid_i,
  input  logic    commit_kill_i,
  issue_if.queue  issue_i,
  exec_if.queue   exec_o
);
  import coproc_pkg::*;

  localparam int unsigned IdxW = $clog2(QueueDepth);

  // Pointers carry one extra wrap bit so full and empty differ
  logic [IdxW:0]   wr_ptr_q;
  logic [IdxW:0]   rd_ptr_q;
  logic [IdxW:0]   cm_ptr_q;
  logic [IdxW:0]   fill;
  logic [IdxW:0]   pending;
  logic [IdxW-1:0] wr_idx;
  logic [IdxW-1:0] rd_idx;
  logic [IdxW-1:0] cm_idx;

  queue_entry_t          mem_q [QueueDepth];
  logic [QueueDepth-1:0] committed_q;
  logic [QueueDepth-1:0] killed_q;

  logic push;
  logic pop;
  logic head_committed;
  logic drop_head;

  assign fill    = wr_ptr_q - rd_ptr_q;
  assign pending = wr_ptr_q - cm_ptr_q;
  assign wr_idx  = wr_ptr_q[IdxW-1:0];
  assign rd_idx  = rd_ptr_q[IdxW-1:0];
  assign cm_idx  = cm_ptr_q[IdxW-1:0];

  assign issue_i.ready = fill < QueueDepth;
  assign push          = issue_i.valid && issue_i.ready;

  assign head_committed = (fill != '0) && committed_q[rd_idx];
  assign exec_o.valid   = head_committed && !killed_q[rd_idx];
  assign exec_o.entry   = mem_q[rd_idx];

  // Killed head leaves without ever being offered
  assign drop_head = head_committed && killed_q[rd_idx];
  assign pop       = drop_head || (exec_o.valid && exec_o.ready);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_idx] <= issue_i.entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      cm_ptr_q    <= '0;
      committed_q <= '0;
      killed_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q            <= wr_ptr_q + 1'b1;
        committed_q[wr_idx] <= 1'b0;
        killed_q[wr_idx]    <= 1'b0;
      end
      // Commit after push so a same-cycle commit of the new entry sticks
      if (commit_valid_i) begin
        cm_ptr_q            <= cm_ptr_q + 1'b1;
        committed_q[cm_idx] <= 1'b1;
        killed_q[cm_idx]    <= commit_kill_i;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill <= QueueDepth)
    else $error("issue queue written while full");

  a_commit_has_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i |-> (pending != '0) || push)
    else $error("commit without an uncommitted instruction");

endmodule

//--- design/result_stage.sv
// Executes the committed head and holds its result in an output register under back-pressure
`timescale 1ns/1ns

module result_stage (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  result_ready_i,
  exec_if.consumer                              exec_i,
  output logic                                  result_valid_o,
  output logic [coproc_pkg::ID_WIDTH-1:0]       result_id_o,
  output logic [coproc_pkg::REG_ADDR_WIDTH-1:0] result_rd_o,
  output logic [coproc_pkg::XLEN-1:0]           result_data_o,
  output logic                                  result_we_o
);
  import coproc_pkg::*;

  logic [XLEN-1:0] func_result;
  logic            load;

  bitfunc_unit u_bitfunc (
    .op_kind_i    (exec_i.entry.op_kind),
    .lane_width_i (exec_i.entry.lane_width),
    .operand_i    (exec_i.entry.rs1),
    .result_o     (func_result)
  );

  // Take a new head when empty or when the current result drains this cycle
  assign exec_i.ready = !result_valid_o || result_ready_i;
  assign load         = exec_i.valid && exec_i.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
    end else if (exec_i.ready) begin
      result_valid_o <= exec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_id_o   <= exec_i.entry.id;
      result_rd_o   <= exec_i.entry.rd;
      result_data_o <= func_result;
    end
  end

  assign result_we_o = result_valid_o;

  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && !result_ready_i |=>
      result_valid_o && $stable(result_id_o) && $stable(result_rd_o)
      && $stable(result_data_o))
    else $error("result changed while stalled");

endmodule

//--- filelist.f
design/coproc_pkg.sv
design/issue_if.sv
design/exec_if.sv
design/instr_decoder.sv
design/issue_queue.sv
design/bitfunc_unit.sv
design/result_stage.sv
design/coproc_top.sv
test/tb_clock_gen.sv
test/tb_coproc.sv

//--- test/tb_clock_gen.sv
// Testbench clock and reset source, a 4 ns clock with active-low reset held for three cycles
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- test/tb_coproc.sv
// Top-level testbench that drives issue and commit traffic into the coprocessor and checks results
`timescale 1ns/1ns

module tb_coproc;
  import coproc_pkg::*;

  localparam int unsigned QueueDepth  = 4;
  localparam int unsigned NumRandom   = 16;
  localparam int unsigned TotalIssues = (2 + NumRandom) + (65 + NumRandom) + 3 * NumRandom
                                        + 4 + QueueDepth + 1;
  localparam int unsigned CycleLimit  = 20 * TotalIssues + 200;
  localparam int unsigned MaxInstr    = 256;
  localparam logic [6:0]  OpcodeOther = 7'b0110011;

  localparam int ReadyRandom = 0;
  localparam int ReadyLow    = 1;
  localparam int ReadyHigh   = 2;

  logic                      clk;
  logic                      rst_n;
  logic                      issue_valid;
  logic [ILEN-1:0]           issue_instr;
  logic [XLEN-1:0]           issue_rs1;
  logic [XLEN-1:0]           issue_rs2;
  logic [ID_WIDTH-1:0]       issue_id;
  logic                      issue_ready;
  logic                      issue_accept;
  logic                      issue_writeback;
  logic                      commit_valid;
  logic                      commit_kill;
  logic                      result_valid;
  logic                      result_ready;
  logic [ID_WIDTH-1:0]       result_id;
  logic [REG_ADDR_WIDTH-1:0] result_rd;
  logic [XLEN-1:0]           result_data;
  logic                      result_we;

  // Expected tuples indexed by accepted sequence number
  logic [ID_WIDTH-1:0]       exp_id     [MaxInstr];
  logic [REG_ADDR_WIDTH-1:0] exp_rd     [MaxInstr];
  logic [XLEN-1:0]           exp_data   [MaxInstr];
  logic                      exp_killed [MaxInstr];

  int unsigned n_accepted;
  int unsigned n_commits;
  int unsigned n_killed;
  int unsigned n_results;
  int unsigned n_sent;
  int unsigned res_ptr;
  int unsigned err_value;
  int unsigned err_other;
  int unsigned cycle_cnt;
  int          ready_mode;
  logic        kill_on;
  logic [ID_WIDTH-1:0] next_id;

  logic                      stall_q;
  logic [ID_WIDTH-1:0]       held_id;
  logic [REG_ADDR_WIDTH-1:0] held_rd;
  logic [XLEN-1:0]           held_data;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  coproc_top #(
    .QueueDepth (QueueDepth)
  ) DUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .issue_valid_i     (issue_valid),
    .issue_instr_i     (issue_instr),
    .issue_rs1_i       (issue_rs1),
    .issue_rs2_i       (issue_rs2),
    .issue_id_i        (issue_id),
    .issue_ready_o     (issue_ready),
    .issue_accept_o    (issue_accept),
    .issue_writeback_o (issue_writeback),
    .commit_valid_i    (commit_valid),
    .commit_kill_i     (commit_kill),
    .result_valid_o    (result_valid),
    .result_ready_i    (result_ready),
    .result_id_o       (result_id),
    .result_rd_o       (result_rd),
    .result_data_o     (result_data),
    .result_we_o       (result_we)
  );

  function automatic logic [XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic expect_accept(input logic [6:0] opcode, input logic [1:0] lane);
    if (opcode == OPCODE_POPCNT || opcode == OPCODE_LEADONE) begin
      return 1'b1;
    end
    return opcode == OPCODE_LANEMAX && lane != 2'b11;
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input logic [6:0] opcode,
                                                  input logic [XLEN-1:0] rs1,
                                                  input logic [1:0] lane);
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] lane_val;
    logic            found;
    int unsigned     w;
    res   = '0;
    found = 1'b0;
    w     = 8 << lane;
    if (opcode == OPCODE_POPCNT) begin
      for (int i = 0; i < XLEN; i++) begin
        res = res + rs1[i];
      end
    end else if (opcode == OPCODE_LEADONE) begin
      // Scan down from the top so a zero operand keeps 0
      for (int i = XLEN - 1; i >= 0; i--) begin
        if (rs1[i] && !found) begin
          res   = i;
          found = 1'b1;
        end
      end
    end else begin
      for (int i = 0; i < XLEN / w; i++) begin
        lane_val = (rs1 >> (i * w)) & ((64'd1 << w) - 1);
        if (lane_val > res) begin
          res = lane_val;
        end
      end
    end
    return res;
  endfunction

  task automatic send_instr(input logic [6:0] opcode, input logic [XLEN-1:0] rs1,
                            input logic [XLEN-1:0] rs2);
    logic [ILEN-1:0] instr;
    instr      = $urandom;
    instr[6:0] = opcode;
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_instr <= instr;
    issue_rs1   <= rs1;
    issue_rs2   <= rs2;
    issue_id    <= next_id;
    next_id = next_id + 1'b1;
    @(negedge clk);
    while (!issue_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic issue_lanemax(input logic [1:0] lane);
    logic [XLEN-1:0] rs2;
    rs2      = rand64();
    rs2[1:0] = lane;
    send_instr(OPCODE_LANEMAX, rand64(), rs2);
  endtask

  task automatic wait_drain();
    while (n_results + n_killed < n_accepted) begin
      @(posedge clk);
    end
  endtask

  task automatic check_result();
    while (res_ptr < n_commits && exp_killed[res_ptr]) begin
      res_ptr++;
    end
    if (res_ptr >= n_commits) begin
      err_other++;
      $display("Result with id %h arrived with no committed instruction waiting", result_id);
    end else begin
      if (result_id !== exp_id[res_ptr]) begin
        err_value++;
        $display("Fail result_id_o: got %h, expected %h", result_id, exp_id[res_ptr]);
      end
      if (result_rd !== exp_rd[res_ptr]) begin
        err_value++;
        $display("Fail result_rd_o: got %h, expected %h", result_rd, exp_rd[res_ptr]);
      end
      if (result_data !== exp_data[res_ptr]) begin
        err_value++;
        $display("Fail result_data_o: got %h, expected %h", result_data, exp_data[res_ptr]);
      end
      if (result_we !== 1'b1) begin
        err_value++;
        $display("Fail result_we_o: got %h, expected %h", result_we, 1'b1);
      end
      res_ptr++;
      n_results++;
    end
  endtask

  task automatic record_commit();
    if (n_commits >= n_accepted) begin
      err_other++;
      $display("Commit seen with no accepted instruction left to commit");
    end else begin
      exp_killed[n_commits] = commit_kill;
      if (commit_kill) begin
        n_killed++;
      end
      n_commits++;
    end
  endtask

  task automatic record_issue();
    logic acc;
    acc = expect_accept(issue_instr[6:0], issue_rs2[1:0]);
    if (issue_accept !== acc) begin
      err_value++;
      $display("Fail issue_accept_o: got %h, expected %h", issue_accept, acc);
    end
    if (issue_writeback !== acc) begin
      err_value++;
      $display("Fail issue_writeback_o: got %h, expected %h", issue_writeback, acc);
    end
    if (acc) begin
      exp_id[n_accepted]     = issue_id;
      exp_rd[n_accepted]     = issue_instr[11:7];
      exp_data[n_accepted]   = ref_result(issue_instr[6:0], issue_rs1, issue_rs2[1:0]);
      exp_killed[n_accepted] = 1'b0;
      n_accepted++;
    end
  endtask

  task automatic check_hold();
    if (result_valid !== 1'b1) begin
      err_other++;
      $display("result_valid_o dropped while the result was stalled");
    end
    if (result_id !== held_id) begin
      err_value++;
      $display("Fail result_id_o: got %h, expected %h", result_id, held_id);
    end
    if (result_rd !== held_rd) begin
      err_value++;
      $display("Fail result_rd_o: got %h, expected %h", result_rd, held_rd);
    end
    if (result_data !== held_data) begin
      err_value++;
      $display("Fail result_data_o: got %h, expected %h", result_data, held_data);
    end
  endtask

  // DUT signals are settled at the falling edge, so every handshake is sampled there
  always @(negedge clk) begin
    if (rst_n) begin
      if (stall_q) begin
        check_hold();
      end
      stall_q   = result_valid && !result_ready;
      held_id   = result_id;
      held_rd   = result_rd;
      held_data = result_data;
      if (result_valid && result_ready) begin
        check_result();
      end
      if (commit_valid) begin
        record_commit();
      end
      if (issue_valid && issue_ready) begin
        record_issue();
      end
    end
  end

  // Commits follow accepted issues in order and result ready follows the current mode
  always @(posedge clk) begin
    commit_valid <= 1'b0;
    commit_kill  <= 1'b0;
    if (rst_n && n_sent < n_accepted && ($urandom % 2 == 0)) begin
      commit_valid <= 1'b1;
      commit_kill  <= kill_on && ($urandom % 4 == 0);
      n_sent++;
    end
    case (ready_mode)
      ReadyLow:  result_ready <= 1'b0;
      ReadyHigh: result_ready <= 1'b1;
      default:   result_ready <= ($urandom % 2 == 0);
    endcase
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("Timeout after %0d cycles, %0d results and %0d kills of %0d accepted",
               cycle_cnt, n_results, n_killed, n_accepted);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h26d1f9ce));
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_id     = '0;
    commit_valid = 1'b0;
    commit_kill  = 1'b0;
    result_ready = 1'b0;
    n_accepted   = 0;
    n_commits    = 0;
    n_killed     = 0;
    n_results    = 0;
    n_sent       = 0;
    res_ptr      = 0;
    err_value    = 0;
    err_other    = 0;
    cycle_cnt    = 0;
    stall_q      = 1'b0;
    next_id      = '0;
    kill_on      = 1'b1;
    ready_mode   = ReadyRandom;
    wait (rst_n === 1'b1);

    send_instr(OPCODE_POPCNT, '0, rand64());
    send_instr(OPCODE_POPCNT, '1, rand64());
    repeat (NumRandom) send_instr(OPCODE_POPCNT, rand64(), rand64());

    for (int i = 0; i < XLEN; i++) begin
      send_instr(OPCODE_LEADONE, 64'd1 << i, rand64());
    end
    send_instr(OPCODE_LEADONE, '0, rand64());
    repeat (NumRandom) send_instr(OPCODE_LEADONE, rand64(), rand64());

    for (int w = 0; w < 3; w++) begin
      repeat (NumRandom) issue_lanemax(w[1:0]);
    end

    // Unknown opcodes and the illegal lane width must be turned away
    send_instr(OpcodeOther, rand64(), rand64());
    send_instr(7'b0000000, rand64(), rand64());
    issue_lanemax(2'b11);
    issue_lanemax(2'b11);

    // Fill the result register and the whole queue while the result is stalled
    wait_drain();
    @(negedge clk);
    kill_on    = 1'b0;
    ready_mode = ReadyLow;
    repeat (QueueDepth + 1) send_instr(OPCODE_POPCNT, rand64(), rand64());
    while (n_commits < n_accepted) begin
      @(posedge clk);
    end
    repeat (3) @(negedge clk);
    if (issue_ready !== 1'b0) begin
      err_value++;
      $display("Fail issue_ready_o: got %h, expected %h", issue_ready, 1'b0);
    end
    ready_mode = ReadyHigh;
    wait_drain();
    repeat (10) @(posedge clk);

    $display("Results checked %0d, kills %0d, value errors %0d, other errors %0d",
             n_results, n_killed, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
